//--- common/self_cmm_pkg.sv
`default_nettype none

package self_cmm_pkg;

    // ---------------------------------------------------------------------
    // Widths
    // ---------------------------------------------------------------------
    localparam int CFG_WORD_W = 16;
    localparam int WORD_IDX_W = 8;
    localparam int CHN_TYPE_W = 5;
    localparam int BOX_MASK_W = 4;

    // Host data word, one per write strobe
    typedef logic [CFG_WORD_W-1:0] cfg_word_t;

    // Position of a word inside the frame
    typedef logic [WORD_IDX_W-1:0] word_idx_t;

    typedef logic [CHN_TYPE_W-1:0] chn_type_t;

    // One bit per slot of an extension box
    typedef logic [BOX_MASK_W-1:0] box_mask_t;

    typedef enum logic {
        ST_OPEN,
        ST_LOCKED
    } cfg_state_t;

    // ---------------------------------------------------------------------
    // Counts
    // ---------------------------------------------------------------------
    localparam int NUM_CHN = 14;
    localparam int NUM_BOX = 4;

    // ---------------------------------------------------------------------
    // Frame layout
    // ---------------------------------------------------------------------
    localparam word_idx_t IDX_CARD_LO   = 8'd0;
    localparam word_idx_t IDX_CARD_HI   = 8'd1;
    localparam word_idx_t IDX_VERSION   = 8'd3;
    localparam word_idx_t IDX_SLOT_EN   = 8'd4;
    localparam word_idx_t IDX_RUN_CYCLE = 8'd6;
    localparam word_idx_t IDX_REDUND    = 8'd7;

    // Channel pair p sits at word IDX_CHN_BASE + p
    localparam word_idx_t IDX_CHN_BASE  = 8'd20;

    // Box pair q sits at word IDX_BOX_BASE + q
    localparam word_idx_t IDX_BOX_BASE  = 8'd28;

    // Count value at which the loader locks
    localparam word_idx_t IDX_LOCK      = 8'd100;

    // Default channel type after reset
    localparam chn_type_t CHN_TYPE_COM3 = 5'd3;

    // Byte lanes of a data word
    localparam int LO_LSB = 0;
    localparam int HI_LSB = 8;

endpackage

`default_nettype wire

//--- verilog/cfg_word_counter.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_word_counter
    import self_cmm_pkg::*;
(
    input  logic      clk_emif,
    input  logic      rst_emif,
    input  logic      wr_sel,
    input  logic      wr_en,
    input  cfg_word_t wr_data,
    output logic      word_stb,
    output word_idx_t word_idx,
    output cfg_word_t word_data
);

    logic sel_d1;
    logic en_d1;

    // ---------------------------------------------------------------------
    // Input stage
    // ---------------------------------------------------------------------
    always_ff @(posedge clk_emif or negedge rst_emif) begin
        if (!rst_emif) begin
            sel_d1    <= 1'b0;
            en_d1     <= 1'b0;
            word_data <= '0;
        end else begin
            sel_d1    <= wr_sel;
            en_d1     <= wr_en;
            word_data <= wr_data;
        end
    end

    assign word_stb = sel_d1 & en_d1;

    // ---------------------------------------------------------------------
    // Word counter
    // ---------------------------------------------------------------------
    // Holds the index of the word currently in the input stage,
    // restarts whenever select drops
    always_ff @(posedge clk_emif or negedge rst_emif) begin
        if (!rst_emif) begin
            word_idx <= '0;
        end else if (!sel_d1) begin
            word_idx <= '0;
        end else if (en_d1) begin
            // Wraps at 256
            word_idx <= word_idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/cfg_frame_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cfg_frame_ctrl
    import self_cmm_pkg::*;
(
    input  logic       clk_emif,
    input  logic       rst_emif,
    input  logic       word_stb,
    input  word_idx_t  word_idx,
    output logic       cfg_wr_ok,
    output logic       ld_card_lo,
    output logic       ld_card_hi,
    output logic       ld_version,
    output logic       ld_slot_en,
    output logic       ld_run_cycle,
    output logic       ld_redund,
    output logic       ld_chn,
    output logic       ld_box,
    output logic [2:0] chn_pair,
    output logic       box_pair
);

    cfg_state_t state;
    cfg_state_t state_nxt;
    word_idx_t  chn_off;
    word_idx_t  box_off;

    // ---------------------------------------------------------------------
    // Lock FSM
    // ---------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            ST_OPEN: begin
                if (word_idx == IDX_LOCK) begin
                    state_nxt = ST_LOCKED;
                end
            end
            ST_LOCKED: begin
                // Only reset leaves this state
                state_nxt = ST_LOCKED;
            end
        endcase
    end

    always_ff @(posedge clk_emif or negedge rst_emif) begin
        if (!rst_emif) begin
            state <= ST_OPEN;
        end else begin
            state <= state_nxt;
        end
    end

    assign cfg_wr_ok = (state == ST_OPEN);

    // ---------------------------------------------------------------------
    // Word index decode
    // ---------------------------------------------------------------------
    // Offsets into the channel and box ranges
    assign chn_off = word_idx - IDX_CHN_BASE;
    assign box_off = word_idx - IDX_BOX_BASE;

    assign chn_pair = chn_off[2:0];
    assign box_pair = box_off[0];

    // Loads keep running after lock
    always_comb begin
        ld_card_lo   = word_stb && (word_idx == IDX_CARD_LO);
        ld_card_hi   = word_stb && (word_idx == IDX_CARD_HI);
        ld_version   = word_stb && (word_idx == IDX_VERSION);
        ld_slot_en   = word_stb && (word_idx == IDX_SLOT_EN);
        ld_run_cycle = word_stb && (word_idx == IDX_RUN_CYCLE);
        ld_redund    = word_stb && (word_idx == IDX_REDUND);
        ld_chn       = word_stb && (word_idx >= IDX_CHN_BASE)
                       && (chn_off < word_idx_t'(NUM_CHN / 2));
        ld_box       = word_stb && (word_idx >= IDX_BOX_BASE)
                       && (box_off < word_idx_t'(NUM_BOX / 2));
    end

endmodule

`default_nettype wire

//--- verilog/card_info_regs.sv
`timescale 1ns/1ps
`default_nettype none

module card_info_regs
    import self_cmm_pkg::*;
(
    input  logic        clk_emif,
    input  logic        rst_emif,
    input  logic        ld_card_lo,
    input  logic        ld_card_hi,
    input  logic        ld_version,
    input  logic        ld_slot_en,
    input  logic        ld_run_cycle,
    input  logic        ld_redund,
    input  cfg_word_t   word_data,
    output logic [31:0] card_id,
    output cfg_word_t   code_version,
    output cfg_word_t   enable_slot,
    output cfg_word_t   run_cycle,
    output logic [7:0]  redundancy_mode
);

    // ---------------------------------------------------------------------
    // Card identity
    // ---------------------------------------------------------------------
    // Card ID arrives as two words, low half first
    always_ff @(posedge clk_emif or negedge rst_emif) begin
        if (!rst_emif) begin
            card_id <= '0;
        end else begin
            if (ld_card_lo) begin
                card_id[15:0] <= word_data;
            end
            if (ld_card_hi) begin
                card_id[31:16] <= word_data;
            end
        end
    end

    // ---------------------------------------------------------------------
    // Board parameters
    // ---------------------------------------------------------------------
    always_ff @(posedge clk_emif or negedge rst_emif) begin
        if (!rst_emif) begin
            code_version    <= '0;
            enable_slot     <= '0;
            run_cycle       <= '0;
            redundancy_mode <= '0;
        end else begin
            if (ld_version) begin
                code_version <= word_data;
            end
            if (ld_slot_en) begin
                enable_slot <= word_data;
            end
            if (ld_run_cycle) begin
                run_cycle <= word_data;
            end
            // Mode lives in the low byte only
            if (ld_redund) begin
                redundancy_mode <= word_data[LO_LSB +: 8];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/slot_type_regs.sv
`timescale 1ns/1ps
`default_nettype none

module slot_type_regs
    import self_cmm_pkg::*;
(
    input  logic                    clk_emif,
    input  logic                    rst_emif,
    input  logic                    ld_chn,
    input  logic      [2:0]         chn_pair,
    input  cfg_word_t               word_data,
    output chn_type_t [NUM_CHN-1:0] chn_type
);

    // ---------------------------------------------------------------------
    // Channel type registers
    // ---------------------------------------------------------------------
    // One word per channel pair, even channel in the low byte,
    // odd channel in the high byte
    always_ff @(posedge clk_emif or negedge rst_emif) begin
        if (!rst_emif) begin
            chn_type <= {NUM_CHN{CHN_TYPE_COM3}};
        end else if (ld_chn) begin
            for (int p = 0; p < NUM_CHN / 2; p++) begin
                if (chn_pair == 3'(p)) begin
                    chn_type[2*p]   <= word_data[LO_LSB +: CHN_TYPE_W];
                    chn_type[2*p+1] <= word_data[HI_LSB +: CHN_TYPE_W];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/ex_box_topology.sv
`timescale 1ns/1ps
`default_nettype none

module ex_box_topology
    import self_cmm_pkg::*;
(
    input  logic                    clk_emif,
    input  logic                    rst_emif,
    input  logic                    ld_box,
    input  logic                    box_pair,
    input  cfg_word_t               word_data,
    output box_mask_t [NUM_BOX-1:0] ex_box_data_ena,
    output box_mask_t [NUM_BOX-1:0] ex_box_cfg_ena
);

    box_mask_t [NUM_BOX-1:0] cfg_nxt;
    box_mask_t               taken;

    // ---------------------------------------------------------------------
    // Data enable masks
    // ---------------------------------------------------------------------
    always_ff @(posedge clk_emif or negedge rst_emif) begin
        if (!rst_emif) begin
            ex_box_data_ena <= '0;
        end else if (ld_box) begin
            // Even box from the low byte, odd box from the high byte
            ex_box_data_ena[2*box_pair]   <= word_data[LO_LSB +: BOX_MASK_W];
            ex_box_data_ena[2*box_pair+1] <= word_data[HI_LSB +: BOX_MASK_W];
        end
    end

    // ---------------------------------------------------------------------
    // Configure enables
    // ---------------------------------------------------------------------
    // Lowest-numbered box wins each slot bit
    always_comb begin
        taken = '0;
        for (int b = 0; b < NUM_BOX; b++) begin
            cfg_nxt[b] = ex_box_data_ena[b] & ~taken;
            taken      = taken | ex_box_data_ena[b];
        end
    end

    always_ff @(posedge clk_emif or negedge rst_emif) begin
        if (!rst_emif) begin
            ex_box_cfg_ena <= '0;
        end else begin
            ex_box_cfg_ena <= cfg_nxt;
        end
    end

endmodule

`default_nettype wire

//--- verilog/self_cmm.sv
`timescale 1ns/1ps
`default_nettype none

module self_cmm
    import self_cmm_pkg::*;
(
    input  logic                    clk_emif,
    input  logic                    rst_emif,
    input  logic                    wr_sel,
    input  logic                    wr_en,
    input  cfg_word_t               wr_data,
    output logic                    cfg_wr_ok,
    output logic [31:0]             card_id,
    output cfg_word_t               code_version,
    output cfg_word_t               enable_slot,
    output cfg_word_t               run_cycle,
    output logic [7:0]              redundancy_mode,
    output chn_type_t [NUM_CHN-1:0] chn_type,
    output box_mask_t [NUM_BOX-1:0] ex_box_data_ena,
    output box_mask_t [NUM_BOX-1:0] ex_box_cfg_ena
);

    logic       word_stb;
    word_idx_t  word_idx;
    cfg_word_t  word_data;
    logic       ld_card_lo;
    logic       ld_card_hi;
    logic       ld_version;
    logic       ld_slot_en;
    logic       ld_run_cycle;
    logic       ld_redund;
    logic       ld_chn;
    logic       ld_box;
    logic [2:0] chn_pair;
    logic       box_pair;

    // ---------------------------------------------------------------------
    // Input stage and frame control
    // ---------------------------------------------------------------------
    cfg_word_counter word_counter_i (
        .clk_emif, .rst_emif, .wr_sel, .wr_en, .wr_data,
        .word_stb, .word_idx, .word_data
    );

    cfg_frame_ctrl frame_ctrl_i (
        .clk_emif, .rst_emif, .word_stb, .word_idx, .cfg_wr_ok,
        .ld_card_lo, .ld_card_hi, .ld_version, .ld_slot_en,
        .ld_run_cycle, .ld_redund, .ld_chn, .ld_box, .chn_pair, .box_pair
    );

    // ---------------------------------------------------------------------
    // Field registers
    // ---------------------------------------------------------------------
    card_info_regs card_info_i (
        .clk_emif, .rst_emif, .ld_card_lo, .ld_card_hi, .ld_version,
        .ld_slot_en, .ld_run_cycle, .ld_redund, .word_data, .card_id,
        .code_version, .enable_slot, .run_cycle, .redundancy_mode
    );

    slot_type_regs slot_type_i (
        .clk_emif, .rst_emif, .ld_chn, .chn_pair, .word_data, .chn_type
    );

    ex_box_topology ex_box_i (
        .clk_emif, .rst_emif, .ld_box, .box_pair, .word_data,
        .ex_box_data_ena, .ex_box_cfg_ena
    );

endmodule

`default_nettype wire

//--- tests/self_cmm_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module self_cmm_checker
    import self_cmm_pkg::*;
(
    input logic                    clk_emif,
    input logic                    rst_emif,
    input cfg_word_t               wr_data,
    input logic                    word_stb,
    input word_idx_t               word_idx,
    input logic                    cfg_wr_ok,
    input logic [31:0]             card_id,
    input cfg_word_t               code_version,
    input cfg_word_t               enable_slot,
    input cfg_word_t               run_cycle,
    input logic [7:0]              redundancy_mode,
    input box_mask_t [NUM_BOX-1:0] ex_box_cfg_ena
);

    int err_cnt = 0;

    // Configure bits regrouped per slot, one bit per box
    logic [NUM_BOX-1:0] slot_cfg [BOX_MASK_W];

    always_comb begin
        for (int s = 0; s < BOX_MASK_W; s++) begin
            for (int b = 0; b < NUM_BOX; b++) begin
                slot_cfg[s][b] = ex_box_cfg_ena[b][s];
            end
        end
    end

    // ----------------------------------------------------------------------
    // Card fields
    // ----------------------------------------------------------------------
    // Each field holds the word taken two edges earlier
    a_card_lo: assert property (@(posedge clk_emif) disable iff (!rst_emif)
        word_stb && (word_idx == IDX_CARD_LO) |=> card_id[15:0] == $past(wr_data, 2))
        else begin
            err_cnt++;
            $error("card_id low half not loaded from word 0");
        end
    a_card_hi: assert property (@(posedge clk_emif) disable iff (!rst_emif)
        word_stb && (word_idx == IDX_CARD_HI) |=> card_id[31:16] == $past(wr_data, 2))
        else begin
            err_cnt++;
            $error("card_id high half not loaded from word 1");
        end
    a_version: assert property (@(posedge clk_emif) disable iff (!rst_emif)
        word_stb && (word_idx == IDX_VERSION) |=> code_version == $past(wr_data, 2))
        else begin
            err_cnt++;
            $error("code_version not loaded from word 3");
        end
    a_slot_en: assert property (@(posedge clk_emif) disable iff (!rst_emif)
        word_stb && (word_idx == IDX_SLOT_EN) |=> enable_slot == $past(wr_data, 2))
        else begin
            err_cnt++;
            $error("enable_slot not loaded from word 4");
        end
    a_run_cyc: assert property (@(posedge clk_emif) disable iff (!rst_emif)
        word_stb && (word_idx == IDX_RUN_CYCLE) |=> run_cycle == $past(wr_data, 2))
        else begin
            err_cnt++;
            $error("run_cycle not loaded from word 6");
        end
    a_redund: assert property (@(posedge clk_emif) disable iff (!rst_emif)
        word_stb && (word_idx == IDX_REDUND) |=> redundancy_mode == $past(wr_data[7:0], 2))
        else begin
            err_cnt++;
            $error("redundancy_mode not loaded from word 7");
        end

    // ----------------------------------------------------------------------
    // Box priority and lock
    // ----------------------------------------------------------------------
    for (genvar s = 0; s < BOX_MASK_W; s++) begin : g_slot
        a_cfg_onehot: assert property (@(posedge clk_emif) disable iff (!rst_emif)
            $onehot0(slot_cfg[s]))
            else begin
                err_cnt++;
                $error("slot %0d configured by more than one box", s);
            end
    end

    a_lock_hold: assert property (@(posedge clk_emif) disable iff (!rst_emif)
        !cfg_wr_ok |=> !cfg_wr_ok)
        else begin
            err_cnt++;
            $error("cfg_wr_ok rose again after lock");
        end
    a_lock_edge: assert property (@(posedge clk_emif) disable iff (!rst_emif)
        $fell(cfg_wr_ok) |-> $past(word_idx) == IDX_LOCK)
        else begin
            err_cnt++;
            $error("cfg_wr_ok fell without word count 100");
        end

endmodule

bind self_cmm self_cmm_checker chk_i (
    .clk_emif, .rst_emif, .wr_data, .word_stb, .word_idx, .cfg_wr_ok, .card_id,
    .code_version, .enable_slot, .run_cycle, .redundancy_mode, .ex_box_cfg_ena
);

`default_nettype wire

//--- tests/self_cmm_tb.sv
`timescale 1ns/1ps
`default_nettype none

module self_cmm_tb
    import self_cmm_pkg::*;
();

    logic                    clk_emif;
    logic                    rst_emif;
    logic                    wr_sel;
    logic                    wr_en;
    cfg_word_t               wr_data;
    logic                    cfg_wr_ok;
    logic [31:0]             card_id;
    cfg_word_t               code_version;
    cfg_word_t               enable_slot;
    cfg_word_t               run_cycle;
    logic [7:0]              redundancy_mode;
    chn_type_t [NUM_CHN-1:0] chn_type;
    box_mask_t [NUM_BOX-1:0] ex_box_data_ena;
    box_mask_t [NUM_BOX-1:0] ex_box_cfg_ena;

    cfg_word_t frame_w [256];
    int cyc = 0;
    int last_stb_cyc;
    int test_errs = 0;
    int chk_base = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int fall_cyc;
    logic taken;
    logic mask_bit;

    self_cmm dut_i (
        .clk_emif, .rst_emif, .wr_sel, .wr_en, .wr_data, .cfg_wr_ok, .card_id,
        .code_version, .enable_slot, .run_cycle, .redundancy_mode, .chn_type,
        .ex_box_data_ena, .ex_box_cfg_ena
    );

    initial begin
        clk_emif = 1'b0;
        forever #20 clk_emif = ~clk_emif;
    end

    always @(posedge clk_emif) cyc <= cyc + 1;

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        if (exp !== act) begin
            $display("mismatch at %0t ns: %s expected 0x%0h actual 0x%0h",
                     $time, name, exp, act);
            test_errs++;
        end
    endtask

    task automatic settle(input int n);
        repeat (n) begin
            @(posedge clk_emif);
            #2;
        end
    endtask

    // One strobe, then idle cycles
    task automatic drive_word(input cfg_word_t w, input int gap);
        wr_en   = 1'b1;
        wr_data = w;
        settle(1);
        last_stb_cyc = cyc;
        wr_en = 1'b0;
        settle(gap);
    endtask

    task automatic write_frame(input int first, input int n);
        wr_sel = 1'b1;
        for (int i = first; i < first + n; i++) begin
            frame_w[i] = cfg_word_t'($urandom);
            drive_word(frame_w[i], $urandom_range(2, 0));
        end
    endtask

    // Loads land two edges after the last strobe
    task automatic end_frame();
        wr_sel = 1'b0;
        settle(3);
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = test_errs + (dut_i.chk_i.err_cnt - chk_base);
        tests_run++;
        if (errs == 0) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed, %0d errors", name, errs);
            tests_failed++;
        end
        test_errs = 0;
        chk_base  = dut_i.chk_i.err_cnt;
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin
        void'($urandom(32'h1cb03f26));
        rst_emif = 1'b0;
        wr_sel   = 1'b0;
        wr_en    = 1'b0;
        wr_data  = '0;
        repeat (8) @(posedge clk_emif);
        #2;
        rst_emif = 1'b1;
        settle(1);

        check_val("cfg_wr_ok", 1, cfg_wr_ok);
        check_val("card_id", 0, card_id);
        check_val("code_version", 0, code_version);
        check_val("enable_slot", 0, enable_slot);
        check_val("run_cycle", 0, run_cycle);
        check_val("redundancy_mode", 0, redundancy_mode);
        check_val("ex_box_data_ena", 0, ex_box_data_ena);
        check_val("ex_box_cfg_ena", 0, ex_box_cfg_ena);
        for (int c = 0; c < NUM_CHN; c++) begin
            check_val($sformatf("chn_type[%0d]", c), CHN_TYPE_COM3, chn_type[c]);
        end
        finish_test("reset_defaults");

        write_frame(0, 8);
        end_frame();
        check_val("card_id", {frame_w[1], frame_w[0]}, card_id);
        check_val("code_version", frame_w[3], code_version);
        check_val("enable_slot", frame_w[4], enable_slot);
        check_val("run_cycle", frame_w[6], run_cycle);
        check_val("redundancy_mode", frame_w[7][7:0], redundancy_mode);
        finish_test("card_fields");

        write_frame(0, 27);
        end_frame();
        for (int c = 0; c < NUM_CHN; c++) begin
            check_val($sformatf("chn_type[%0d]", c),
                      frame_w[20 + c / 2][(c % 2) * 8 +: 5], chn_type[c]);
        end
        finish_test("channel_types");

        write_frame(0, 30);
        end_frame();
        for (int s = 0; s < BOX_MASK_W; s++) begin
            taken = 1'b0;
            for (int b = 0; b < NUM_BOX; b++) begin
                mask_bit = frame_w[28 + b / 2][(b % 2) * 8 + s];
                check_val($sformatf("ex_box_data_ena[%0d][%0d]", b, s),
                          mask_bit, ex_box_data_ena[b][s]);
                check_val($sformatf("ex_box_cfg_ena[%0d][%0d]", b, s),
                          mask_bit & ~taken, ex_box_cfg_ena[b][s]);
                taken = taken | mask_bit;
            end
        end
        finish_test("box_priority");

        // Drop select mid frame so the new frame starts over at word 0
        write_frame(0, 5);
        wr_sel = 1'b0;
        settle(2);
        write_frame(8, 2);
        end_frame();
        check_val("card_id", {frame_w[9], frame_w[8]}, card_id);
        check_val("code_version", frame_w[3], code_version);
        finish_test("frame_restart");

        check_val("cfg_wr_ok", 1, cfg_wr_ok);
        write_frame(0, 99);
        drive_word(16'h5a5a, 0);
        fall_cyc = -1;
        for (int t = 0; t < 20 && fall_cyc < 0; t++) begin
            settle(1);
            if (!cfg_wr_ok) fall_cyc = cyc;
        end
        if (fall_cyc < 0) begin
            $display("timeout: cfg_wr_ok still high 20 cycles after word 100");
            test_errs++;
        end else begin
            // Count reaches 100 one edge after word 100 is taken, lock one edge later
            check_val("cfg_wr_ok fall cycle", last_stb_cyc + 2, fall_cyc);
        end
        write_frame(100, 10);
        end_frame();
        // Loads still run once locked
        write_frame(0, 4);
        end_frame();
        check_val("cfg_wr_ok", 0, cfg_wr_ok);
        check_val("card_id", {frame_w[1], frame_w[0]}, card_id);
        finish_test("lock");

        $display("tests run %0d, failed %0d, assertion errors %0d",
                 tests_run, tests_failed, dut_i.chk_i.err_cnt);
        if (tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- self_cmm.f
common/self_cmm_pkg.sv
verilog/cfg_word_counter.sv
verilog/cfg_frame_ctrl.sv
verilog/card_info_regs.sv
verilog/slot_type_regs.sv
verilog/ex_box_topology.sv
verilog/self_cmm.sv
tests/self_cmm_asserts.sv
tests/self_cmm_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -Wno-fatal
TOP       = self_cmm_tb
FILELIST  = self_cmm.f
BUILD_DIR = obj_dir
SIM_ARGS  = +verilator+error+limit+1000
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | awk '{ print } index($$0, "$(PASS_MSG)") { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)
